// ==== Bender.yml ====
package:
  name: lsp

sources:
  - include_dirs:
      - .
    files:
      - lspTypesPkg.sv
      - lspTablesPkg.sv
      - lspIfs.sv
      - coeffBuilder.sv
      - chebEval.sv
      - rootSearch.sv
      - lspStore.sv
      - lspTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbLsp.sv

// ==== chebEval.sv ====
`include "lsp_macros.svh"

module chebEval import lspTypesPkg::*; (
	input logic clk,
	input logic reset,
	input polyCoeffsT coeffs,
	chebIf.slave cheb
);

	localparam int LAST_STEP = `POLY_COEFFS - 1;

	logic [2:0] step; // Zero while idle
	accT b1;
	accT b2;
	wordT coef;
	accT coefExt;
	accT prod;
	accT stepSum;
	logic isLast;

	////////////////////
	// Shared multiplier and adder

	assign coef = cheb.polySel ? coeffs.diffPoly[step] : coeffs.sumPoly[step];
	assign coefExt = accT'(coef);
	assign prod = accT'(cheb.evalX) * b1;
	assign isLast = (step == 3'(LAST_STEP));

	// Final step halves both the product and the tail coefficient
	assign stepSum = (isLast ? (prod >>> 15) : (prod >>> 14)) - b2
		+ (isLast ? (coefExt >>> 1) : coefExt);

	////////////////////
	// Step sequencing

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			step <= '0;
			cheb.evalDone <= 1'b0;
		end
		else
		begin
			cheb.evalDone <= 1'b0;
			if (step == '0)
			begin
				if (cheb.evalStart)
					step <= 3'd1;
			end
			else if (isLast)
			begin
				step <= '0;
				cheb.evalDone <= 1'b1;
			end
			else
				step <= step + 3'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (step == '0)
		begin
			b1 <= coefExt; // c0 is ready when start arrives
			b2 <= '0;
		end
		else if (!isLast)
		begin
			b2 <= b1;
			b1 <= stepSum;
		end
		else
			cheb.evalResult <= stepSum;
	end

endmodule

// ==== coeffBuilder.sv ====
`include "lsp_macros.svh"

module coeffBuilder import lspTypesPkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic aWrite,
	input logic [3:0] aAddr,
	input wordT aData,
	output polyCoeffsT coeffs,
	output logic coeffReady,
	output logic busy,
	input logic frameDone
);

	wordT aReg [1:`LSP_ORDER];
	logic building;
	logic [2:0] stepIdx;
	logic [3:0] loIdx;
	logic [3:0] hiIdx;
	wordT pairSum;
	wordT pairDiff;
	wordT sumTerm;
	wordT diffTerm;
	logic startOk;

	assign startOk = start && !busy;

	// a[i+1] paired with a[10-i]
	assign loIdx = {1'b0, stepIdx} + 4'd1;
	assign hiIdx = 4'(`LSP_ORDER) - {1'b0, stepIdx};
	assign pairSum = aReg[loIdx] + aReg[hiIdx];
	assign pairDiff = aReg[loIdx] - aReg[hiIdx];
	assign sumTerm = pairSum >>> 2;
	assign diffTerm = pairDiff >>> 2;

	always_ff @(posedge clk)
	begin
		if (aWrite && !busy && aAddr >= 4'd1 && aAddr <= 4'(`LSP_ORDER))
			aReg[aAddr] <= aData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			building <= 1'b0;
			stepIdx <= '0;
			coeffReady <= 1'b0;
		end
		else
		begin
			coeffReady <= 1'b0;
			if (startOk)
			begin
				busy <= 1'b1;
				building <= 1'b1;
				stepIdx <= '0;
			end
			else if (frameDone)
				busy <= 1'b0;
			if (building)
			begin
				stepIdx <= stepIdx + 3'd1;
				if (stepIdx == 3'(`POLY_COEFFS - 2))
				begin
					building <= 1'b0;
					coeffReady <= 1'b1; // Last coefficient lands with this edge
				end
			end
		end
	end

	// One coefficient pair per cycle
	always_ff @(posedge clk)
	begin
		if (startOk)
		begin
			coeffs.sumPoly[0] <= wordT'(`COEFF_INIT);
			coeffs.diffPoly[0] <= wordT'(`COEFF_INIT);
		end
		else if (building)
		begin
			coeffs.sumPoly[loIdx] <= sumTerm - coeffs.sumPoly[stepIdx];
			coeffs.diffPoly[loIdx] <= diffTerm + coeffs.diffPoly[stepIdx];
		end
	end

endmodule

// ==== lspIfs.sv ====
interface chebIf import lspTypesPkg::*; ();
	logic evalStart;
	wordT evalX;      // Held until evalDone
	logic polySel;    // High picks the difference polynomial
	logic evalDone;
	accT evalResult;

	modport master (output evalStart, evalX, polySel, input evalDone, evalResult);
	modport slave (input evalStart, evalX, polySel, output evalDone, evalResult);
endinterface

interface rootIf import lspTypesPkg::*; ();
	logic rootValid;
	logic [3:0] rootIndex;
	wordT rootData;
	logic searchDone;
	logic [3:0] rootCount; // Qualified by searchDone

	modport master (output rootValid, rootIndex, rootData, searchDone, rootCount);
	modport slave (input rootValid, rootIndex, rootData, searchDone, rootCount);
endinterface

// ==== lspStore.sv ====
`include "lsp_macros.svh"

module lspStore import lspTypesPkg::*, lspTablesPkg::*; (
	input logic clk,
	input logic reset,
	rootIf.slave root,
	output logic lspValid,
	output logic [3:0] lspIndex,
	output wordT lspData,
	output logic usedOld,
	output logic done
);

	storeStateT state;
	wordT newBank [0:`LSP_ORDER-1];
	wordT oldBank [0:`LSP_ORDER-1];
	logic [3:0] streamIdx;
	logic lastOut;

	assign lastOut = lspValid && (lspIndex == 4'(`LSP_ORDER - 1));

	always_ff @(posedge clk)
	begin
		if (root.rootValid)
			newBank[root.rootIndex] <= root.rootData;
	end

	////////////////////
	// Fallback and streaming

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stCollect;
			streamIdx <= '0;
			usedOld <= 1'b0;
			lspValid <= 1'b0;
			done <= 1'b0;
			for (int i = 0; i < `LSP_ORDER; i++)
				oldBank[i] <= lspDefault[i];
		end
		else
		begin
			lspValid <= 1'b0;
			done <= lastOut; // One cycle behind the last word
			case (state)
				stCollect:
				begin
					if (root.searchDone)
					begin
						usedOld <= (root.rootCount != 4'(`LSP_ORDER));
						streamIdx <= '0;
						state <= stStream;
					end
				end
				stStream:
				begin
					lspValid <= 1'b1;
					lspIndex <= streamIdx;
					if (usedOld)
						lspData <= oldBank[streamIdx];
					else
					begin
						lspData <= newBank[streamIdx];
						oldBank[streamIdx] <= newBank[streamIdx]; // Good frame becomes history
					end
					streamIdx <= streamIdx + 4'd1;
					if (streamIdx == 4'(`LSP_ORDER - 1))
						state <= stCollect;
				end
				default:
					state <= stCollect;
			endcase
		end
	end

endmodule

// ==== lspTablesPkg.sv ====
`include "lsp_macros.svh"

package lspTablesPkg;
	import lspTypesPkg::*;

	// 32760 * cos(pi * j / 60)
	localparam wordT cosGrid [0:`GRID_POINTS-1] = '{
		32760, 32715, 32581, 32357, 32044, 31644, 31157, 30584,
		29928, 29189, 28371, 27475, 26503, 25459, 24345, 23165,
		21921, 20617, 19256, 17842, 16380, 14873, 13325, 11740,
		10123, 8479, 6811, 5125, 3424, 1715, 0,
		-1715, -3424, -5125, -6811, -8479, -10123, -11740, -13325,
		-14873, -16380, -17842, -19256, -20617, -21921, -23165, -24345,
		-25459, -26503, -27475, -28371, -29189, -29928, -30584, -31157,
		-31644, -32044, -32357, -32581, -32715, -32760
	};

	// Old LSP bank contents after reset
	localparam wordT lspDefault [0:`LSP_ORDER-1] = '{
		30000, 26000, 21000, 15000, 8000,
		0, -8000, -15000, -21000, -26000
	};

endpackage

// ==== lspTop.sv ====
module lspTop import lspTypesPkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic aWrite,
	input logic [3:0] aAddr,
	input wordT aData,
	output logic busy,
	output logic lspValid,
	output logic [3:0] lspIndex,
	output wordT lspData,
	output logic usedOld,
	output logic done
);

	polyCoeffsT coeffs;
	logic coeffReady;

	chebIf chebBus ();
	rootIf rootBus ();

	// Frame control and polynomial build
	coeffBuilder u_coeffBuilder (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.aWrite     (aWrite),
		.aAddr      (aAddr),
		.aData      (aData),
		.coeffs     (coeffs),
		.coeffReady (coeffReady),
		.busy       (busy),
		.frameDone  (done)
	);

	chebEval u_chebEval (
		.clk    (clk),
		.reset  (reset),
		.coeffs (coeffs),
		.cheb   (chebBus.slave)
	);

	rootSearch u_rootSearch (
		.clk        (clk),
		.reset      (reset),
		.coeffReady (coeffReady),
		.cheb       (chebBus.master),
		.root       (rootBus.master)
	);

	lspStore u_lspStore (
		.clk      (clk),
		.reset    (reset),
		.root     (rootBus.slave),
		.lspValid (lspValid),
		.lspIndex (lspIndex),
		.lspData  (lspData),
		.usedOld  (usedOld),
		.done     (done)
	);

endmodule

// ==== lspTypesPkg.sv ====
`include "lsp_macros.svh"

package lspTypesPkg;

	typedef logic signed [`WORD_W-1:0] wordT;
	typedef logic signed [`ACC_W-1:0] accT;

	// Sum and difference polynomials with the leading term at index 0
	typedef struct packed {
		wordT [`POLY_COEFFS-1:0] sumPoly;
		wordT [`POLY_COEFFS-1:0] diffPoly;
	} polyCoeffsT;

	typedef enum logic [2:0] {
		sIdle,
		sGridStep,
		sEvalWait,
		sBracketTest,
		sBisect,
		sEmit,
		sDone
	} searchStateT;

	typedef enum logic {
		stCollect,
		stStream
	} storeStateT;

endpackage

// ==== lsp_macros.svh ====
`ifndef LSP_MACROS_SVH
`define LSP_MACROS_SVH

// Frame geometry
`define LSP_ORDER     10
`define POLY_COEFFS   6
`define GRID_POINTS   61
`define BISECT_STEPS  4

// Leading coefficient of both polynomials
`define COEFF_INIT    1024

// Datapath widths
`define WORD_W        16
`define ACC_W         32

`endif

// ==== rootSearch.sv ====
`include "lsp_macros.svh"

module rootSearch import lspTypesPkg::*, lspTablesPkg::*; (
	input logic clk,
	input logic reset,
	input logic coeffReady,
	chebIf.master cheb,
	rootIf.master root
);

	searchStateT state;
	logic [5:0] gridIdx;
	logic [3:0] rootCnt;
	logic [2:0] bisCnt;
	logic polySel;
	logic evalMid;  // Pending evaluation is at xMid
	logic evalTest; // Bracket test follows
	wordT xLow;
	wordT xHigh;
	wordT xMid;
	accT yLow;
	accT yHigh;
	wordT xHalf;
	logic [5:0] nextIdx;
	logic midBelow;
	logic bracket;

	assign xHalf = (xLow >>> 1) + (xHigh >>> 1);
	assign nextIdx = gridIdx + 6'd1;

	// Root lies between low and mid
	assign midBelow = (yLow[`ACC_W-1] != cheb.evalResult[`ACC_W-1])
		|| (cheb.evalResult == '0);
	assign bracket = (yLow == '0) || (yLow[`ACC_W-1] != yHigh[`ACC_W-1]);

	assign cheb.evalX = evalMid ? xMid : xLow;
	assign cheb.polySel = polySel;
	assign root.rootCount = rootCnt;

	////////////////////
	// Search FSM

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sIdle;
			gridIdx <= '0;
			rootCnt <= '0;
			bisCnt <= '0;
			polySel <= 1'b0;
			evalMid <= 1'b0;
			evalTest <= 1'b0;
			cheb.evalStart <= 1'b0;
			root.rootValid <= 1'b0;
			root.searchDone <= 1'b0;
		end
		else
		begin
			cheb.evalStart <= 1'b0;
			root.rootValid <= 1'b0;
			root.searchDone <= 1'b0;
			case (state)
				sIdle:
				begin
					if (coeffReady)
					begin
						gridIdx <= '0;
						rootCnt <= '0;
						polySel <= 1'b0; // Sum polynomial first
						xLow <= cosGrid[0];
						evalMid <= 1'b0;
						evalTest <= 1'b0;
						cheb.evalStart <= 1'b1;
						state <= sEvalWait;
					end
				end
				sEvalWait:
				begin
					if (cheb.evalDone && evalMid)
					begin
						if (midBelow)
						begin
							xHigh <= xMid;
							yHigh <= cheb.evalResult;
						end
						else
						begin
							xLow <= xMid;
							yLow <= cheb.evalResult;
						end
						bisCnt <= bisCnt + 3'd1;
						if (bisCnt == 3'(`BISECT_STEPS - 1))
							state <= sEmit;
						else
							state <= sBisect;
					end
					else if (cheb.evalDone)
					begin
						yLow <= cheb.evalResult;
						if (evalTest)
							state <= sBracketTest;
						else
							state <= sGridStep;
					end
				end
				sGridStep:
				begin
					if (rootCnt < 4'(`LSP_ORDER) && gridIdx < 6'(`GRID_POINTS - 1))
					begin
						gridIdx <= nextIdx;
						xHigh <= xLow;
						yHigh <= yLow;
						xLow <= cosGrid[nextIdx];
						evalMid <= 1'b0;
						evalTest <= 1'b1;
						cheb.evalStart <= 1'b1;
						state <= sEvalWait;
					end
					else
						state <= sDone;
				end
				sBracketTest:
				begin
					bisCnt <= '0;
					if (bracket)
						state <= sBisect;
					else
						state <= sGridStep;
				end
				sBisect:
				begin
					xMid <= xHalf;
					evalMid <= 1'b1;
					cheb.evalStart <= 1'b1;
					state <= sEvalWait;
				end
				sEmit:
				begin
					root.rootValid <= 1'b1;
					root.rootIndex <= rootCnt;
					root.rootData <= xHalf;
					rootCnt <= rootCnt + 4'd1;
					xLow <= xHalf;
					polySel <= !polySel; // Roots alternate between polynomials
					evalMid <= 1'b0;
					evalTest <= 1'b0;
					cheb.evalStart <= 1'b1;
					state <= sEvalWait;
				end
				sDone:
				begin
					root.searchDone <= 1'b1;
					state <= sIdle;
				end
				default:
					state <= sIdle;
			endcase
		end
	end

endmodule

// ==== tb.f ====
+incdir+.
lspTypesPkg.sv
lspTablesPkg.sv
lspIfs.sv
coeffBuilder.sv
chebEval.sv
rootSearch.sv
lspStore.sv
lspTop.sv
tbLsp.sv

// ==== tbLspModel.svh ====
`ifndef TB_LSP_MODEL_SVH
`define TB_LSP_MODEL_SVH

logic [31:0] lfsr;
int checkCount;
int errCount;

wordT modelA [1:`LSP_ORDER];
wordT modelSum [0:`POLY_COEFFS-1];
wordT modelDiff [0:`POLY_COEFFS-1];
wordT modelRoot [0:`LSP_ORDER-1];
wordT modelOld [0:`LSP_ORDER-1];
wordT expLsp [0:`LSP_ORDER-1];
logic expUsedOld;

////////////////////
// Galois LFSR stepped once per bit

function automatic logic [31:0] takeBits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		v = {v[30:0], lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
	end
	return v;
endfunction

function automatic void randomCoeffs(input int shift);
	for (int i = 1; i <= `LSP_ORDER; i++)
		modelA[i] = wordT'(takeBits(16)) >>> shift;
endfunction

////////////////////
// Reference model

function automatic void buildPolys();
	wordT t;
	modelSum[0] = wordT'(`COEFF_INIT);
	modelDiff[0] = wordT'(`COEFF_INIT);
	for (int i = 0; i < `POLY_COEFFS - 1; i++)
	begin
		t = modelA[i + 1] + modelA[`LSP_ORDER - i]; // 16-bit wrap
		modelSum[i + 1] = (t >>> 2) - modelSum[i];
		t = modelA[i + 1] - modelA[`LSP_ORDER - i];
		modelDiff[i + 1] = (t >>> 2) + modelDiff[i];
	end
endfunction

function automatic accT coefAt(input logic useDiff, input int k);
	return useDiff ? accT'(modelDiff[k]) : accT'(modelSum[k]);
endfunction

// Clenshaw recurrence with x in Q15
function automatic accT chebValue(input wordT x, input logic useDiff);
	accT xExt;
	accT prod;
	accT b0;
	accT b1;
	accT b2;
	xExt = x;
	b1 = coefAt(useDiff, 0);
	b2 = 0;
	for (int k = 1; k < `POLY_COEFFS - 1; k++)
	begin
		prod = xExt * b1;
		b0 = (prod >>> 14) - b2 + coefAt(useDiff, k);
		b2 = b1;
		b1 = b0;
	end
	prod = xExt * b1;
	return (prod >>> 15) - b2 + (coefAt(useDiff, `POLY_COEFFS - 1) >>> 1);
endfunction

function automatic int findRoots();
	int j;
	int count;
	logic useDiff;
	wordT xLo;
	wordT xHi;
	wordT xMid;
	accT yLo;
	accT yHi;
	accT yMid;
	j = 0;
	count = 0;
	useDiff = 1'b0;
	xLo = cosGrid[0];
	yLo = chebValue(xLo, useDiff);
	while (count < `LSP_ORDER && j < `GRID_POINTS - 1)
	begin
		j++;
		xHi = xLo;
		yHi = yLo;
		xLo = cosGrid[j];
		yLo = chebValue(xLo, useDiff);
		if (yLo == 0 || ((yLo < 0) != (yHi < 0)))
		begin
			for (int s = 0; s < `BISECT_STEPS; s++)
			begin
				xMid = (xLo >>> 1) + (xHi >>> 1);
				yMid = chebValue(xMid, useDiff);
				if (((yLo < 0) != (yMid < 0)) || yMid == 0)
				begin
					xHi = xMid;
					yHi = yMid;
				end
				else
				begin
					xLo = xMid;
					yLo = yMid;
				end
			end
			xMid = (xLo >>> 1) + (xHi >>> 1); // Root is the bracket midpoint
			modelRoot[count] = xMid;
			count++;
			xLo = xMid;
			useDiff = !useDiff;
			yLo = chebValue(xLo, useDiff);
		end
	end
	return count;
endfunction

function automatic void predictFrame();
	int found;
	buildPolys();
	found = findRoots();
	expUsedOld = (found != `LSP_ORDER);
	for (int i = 0; i < `LSP_ORDER; i++)
	begin
		if (!expUsedOld)
			modelOld[i] = modelRoot[i];
		expLsp[i] = modelOld[i];
	end
endfunction

task automatic checkValue(input logic signed [63:0] got, input logic signed [63:0] want,
		input string what);
	checkCount++;
	if (got !== want)
	begin
		errCount++;
		$display("FAIL %0t: %s, got %0d, expected %0d", $time, what, got, want);
	end
endtask

`endif

// ==== tbLsp.sv ====
`include "lsp_macros.svh"

module tbLsp import lspTypesPkg::*, lspTablesPkg::*; ();

	localparam int FRAME_LIMIT = 5000;
	localparam int IDLE_LIMIT = 20;

	logic clk;
	logic reset;
	logic start;
	logic aWrite;
	logic [3:0] aAddr;
	wordT aData;
	logic busy;
	logic lspValid;
	logic [3:0] lspIndex;
	wordT lspData;
	logic usedOld;
	logic done;

	logic timedOut;
	wordT gotLsp [0:`LSP_ORDER-1];
	logic gotUsedOld;

	`include "tbLspModel.svh"

	lspTop u_lspTop (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.aWrite   (aWrite),
		.aAddr    (aAddr),
		.aData    (aData),
		.busy     (busy),
		.lspValid (lspValid),
		.lspIndex (lspIndex),
		.lspData  (lspData),
		.usedOld  (usedOld),
		.done     (done)
	);

	always #10 clk = ~clk;

	////////////////////
	// Stimulus tasks

	task automatic loadCoeffs();
		for (int i = 1; i <= `LSP_ORDER; i++)
		begin
			@(posedge clk);
			aWrite <= 1'b1;
			aAddr <= 4'(i);
			aData <= modelA[i];
		end
		@(posedge clk);
		aWrite <= 1'b0;
	endtask

	task automatic checkQuiet(input string label, input int cycles, input logic withUsedOld);
		for (int i = 0; i < cycles; i++)
		begin
			@(posedge clk);
			checkValue(busy, 0, {label, " busy"});
			checkValue(lspValid, 0, {label, " lspValid"});
			checkValue(done, 0, {label, " done"});
			if (withUsedOld)
				checkValue(usedOld, 0, {label, " usedOld"});
		end
	endtask

	task automatic waitIdle(input string label);
		int cycles;
		cycles = 0;
		while (busy && !timedOut)
		begin
			@(posedge clk);
			cycles++;
			if (busy && cycles >= IDLE_LIMIT)
			begin
				$display("Timeout: busy stayed high after done in %s", label);
				timedOut = 1'b1;
			end
		end
	endtask

	task automatic runFrame(input string label, input logic doLoad, input int extraStartAt,
			input logic busyWrites);
		int cycles;
		int words;
		logic doneSeen;
		logic lastSeen;
		if (timedOut)
			return;
		predictFrame();
		if (doLoad)
			loadCoeffs();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		cycles = 0;
		words = 0;
		doneSeen = 1'b0;
		lastSeen = 1'b0;
		while (!doneSeen && !timedOut)
		begin
			@(posedge clk);
			cycles++;
			checkValue(busy, 1, {label, " busy during frame"});
			if (extraStartAt > 0)
				start <= (cycles == extraStartAt)
					|| (lspValid && lspIndex == 4'(`LSP_ORDER - 1)); // Mid-frame and in the done cycle
			if (busyWrites && cycles >= 3 && cycles < 13)
			begin
				aWrite <= 1'b1;
				aAddr <= 4'(takeBits(4) % 10 + 1);
				aData <= wordT'(takeBits(16));
			end
			else
				aWrite <= 1'b0;
			if (lspValid)
			begin
				if (words < `LSP_ORDER)
				begin
					checkValue(lspIndex, words, {label, " lspIndex"});
					checkValue(lspData, expLsp[words], {label, " lspData"});
					checkValue(usedOld, expUsedOld, {label, " usedOld"});
					gotLsp[words] = lspData;
					gotUsedOld = usedOld;
				end
				words++;
			end
			else if (words > 0 && words < `LSP_ORDER)
				checkValue(lspValid, 1, {label, " gap in stream"});
			if (done)
			begin
				doneSeen = 1'b1;
				checkValue(words, `LSP_ORDER, {label, " words before done"});
				checkValue(lastSeen, 1, {label, " done right after last word"});
			end
			lastSeen = lspValid && (lspIndex == 4'(`LSP_ORDER - 1));
			if (!doneSeen && cycles >= FRAME_LIMIT)
			begin
				$display("Timeout: no done within %0d cycles in %s", FRAME_LIMIT, label);
				timedOut = 1'b1;
			end
		end
		start <= 1'b0;
		aWrite <= 1'b0;
		waitIdle(label);
		if (extraStartAt > 0 && !timedOut)
			checkQuiet({label, " after done"}, 40, 1'b0); // No second frame
	endtask

	////////////////////
	// Frame sequence

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		aWrite = 1'b0;
		aAddr = '0;
		aData = '0;
		lfsr = 32'hd199;
		checkCount = 0;
		errCount = 0;
		timedOut = 1'b0;
		for (int i = 0; i < `LSP_ORDER; i++)
			modelOld[i] = lspDefault[i];
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		checkQuiet("after reset", 20, 1'b1);

		// Sum polynomial becomes 1024*T5 + 4000 with no sign change
		for (int i = 1; i <= `LSP_ORDER; i++)
			modelA[i] = '0;
		modelA[1] = 16'sd2048;
		modelA[10] = 16'sd2048;
		modelA[5] = 16'sd16000;
		modelA[6] = 16'sd16000;
		runFrame("default fallback", 1'b1, 0, 1'b0);
		if (!timedOut)
		begin
			checkValue(gotUsedOld, 1, "default fallback usedOld");
			for (int i = 0; i < `LSP_ORDER; i++)
				checkValue(gotLsp[i], lspDefault[i], "default fallback data");
		end

		for (int f = 0; f < 3; f++)
		begin
			randomCoeffs(7);
			runFrame("stable filter", 1'b1, 0, 1'b0);
			if (!timedOut)
				checkValue(gotUsedOld, 0, "stable filter usedOld");
		end

		for (int f = 0; f < 4; f++)
		begin
			randomCoeffs(0);
			runFrame("random coefficients", 1'b1, 0, 1'b0);
		end

		for (int i = 1; i <= `LSP_ORDER; i++)
			modelA[i] = '0;
		runFrame("zero coefficients", 1'b1, 0, 1'b0);

		randomCoeffs(7);
		runFrame("start while busy", 1'b1, 20, 1'b0);

		// Second frame reuses the held coefficients
		randomCoeffs(7);
		runFrame("writes while busy", 1'b1, 0, 1'b1);
		runFrame("frame after busy writes", 1'b0, 0, 1'b0);

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errCount, timedOut);
		if (errCount == 0 && !timedOut)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
